// File: compile.f
+incdir+sim
src/proxy_pkg.sv
src/clear_addr_counter.sv
src/mem_ram_sp.sv
src/mem_proxy_ctrl.sv
src/proxy_regs.sv
src/proxy_top.sv
sim/tb_proxy_top.sv

// File: Bender.yml
package:
  name: mem_proxy

sources:
  - src/proxy_pkg.sv
  - src/clear_addr_counter.sv
  - src/mem_ram_sp.sv
  - src/mem_proxy_ctrl.sv
  - src/proxy_regs.sv
  - src/proxy_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_proxy_top.sv

// File: sim/tb_host_tasks.svh
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// Host register writes, one strobe, ack expected on the next cycle
task automatic reg_write(input logic [proxy_pkg::REG_ADDR_WID-1:0] addr,
                         input logic [proxy_pkg::REG_DATA_WID-1:0] data);
    int cycles;
    @(posedge clk);
    #1;
    i_wr      = 1'b1;
    i_wr_addr = addr;
    i_wr_data = data;
    @(posedge clk);
    #1;
    i_wr   = 1'b0;
    cycles = 0;
    while (!o_wr_ack && cycles < 4) begin
        @(posedge clk);
        #1;
        cycles++;
    end
    if (!o_wr_ack) begin
        $display("register write to word %0d got no acknowledge", addr);
        error_count++;
    end
endtask

// Host register reads, data is taken in the ack cycle
task automatic reg_read(input  logic [proxy_pkg::REG_ADDR_WID-1:0] addr,
                        output logic [proxy_pkg::REG_DATA_WID-1:0] data);
    int cycles;
    @(posedge clk);
    #1;
    i_rd      = 1'b1;
    i_rd_addr = addr;
    @(posedge clk);
    #1;
    i_rd   = 1'b0;
    cycles = 0;
    while (!o_rd_ack && cycles < 4) begin
        @(posedge clk);
        #1;
        cycles++;
    end
    if (!o_rd_ack) begin
        $display("register read of word %0d got no acknowledge", addr);
        error_count++;
    end
    data = o_rd_data;
endtask

// Poll REG_STATUS until one bit is set
task automatic wait_status(input  int                                bit_idx,
                           output logic [proxy_pkg::REG_DATA_WID-1:0] status);
    int polls;
    polls = 0;
    reg_read(proxy_pkg::REG_STATUS, status);
    while (!status[bit_idx] && polls < MAX_POLLS) begin
        reg_read(proxy_pkg::REG_STATUS, status);
        polls++;
    end
    if (!status[bit_idx]) begin
        $display("status bit %0d still clear after %0d polls", bit_idx, polls);
        error_count++;
    end
endtask

`endif

// File: sim/tb_proxy_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_proxy_top;

    localparam int DEPTH      = 256;
    localparam int CLK_PERIOD = 20;
    localparam int DW         = proxy_pkg::REG_DATA_WID;
    localparam int AW         = proxy_pkg::REG_ADDR_WID;
    localparam int MAX_POLLS  = DEPTH + 16;
    localparam int BUSY       = proxy_pkg::STATUS_BUSY_BIT;
    localparam int DONE       = proxy_pkg::STATUS_DONE_BIT;
    localparam int ERR        = proxy_pkg::STATUS_ERROR_BIT;
    localparam int INIT       = proxy_pkg::STATUS_INIT_DONE_BIT;
    // 2000 accesses at up to 4 cycles each, plus four clears with margin
    localparam int WATCHDOG_NS = (2000 * 4 + 4 * (DEPTH + 16)) * CLK_PERIOD;

    logic          clk;
    logic          srst;
    logic          i_wr;
    logic [AW-1:0] i_wr_addr;
    logic [DW-1:0] i_wr_data;
    logic          o_wr_ack;
    logic          i_rd;
    logic [AW-1:0] i_rd_addr;
    logic [DW-1:0] o_rd_data;
    logic          o_rd_ack;

    int            error_count;
    int            tests_passed;
    int            tests_failed;
    logic [DW-1:0] model [int];
    int            written_addrs [$];

    proxy_top #(
        .DEPTH ( DEPTH )
    ) u_proxy_top (
        .clk       ( clk ),
        .srst      ( srst ),
        .i_wr      ( i_wr ),
        .i_wr_addr ( i_wr_addr ),
        .i_wr_data ( i_wr_data ),
        .o_wr_ack  ( o_wr_ack ),
        .i_rd      ( i_rd ),
        .i_rd_addr ( i_rd_addr ),
        .o_rd_data ( o_rd_data ),
        .o_rd_ack  ( o_rd_ack )
    );

    `include "tb_host_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the tests did not finish", $time);
        $display("sim failed");
        $finish;
    end

    // ------------------------------
    // Handshake protocol
    // ------------------------------
    assert property (@(posedge clk) disable iff (srst) i_wr |=> o_wr_ack)
        else begin
            $display("[ERROR] %0t: write ack missing one cycle after strobe", $time);
            error_count++;
        end
    assert property (@(posedge clk) disable iff (srst) o_wr_ack |-> $past(i_wr))
        else begin
            $display("[ERROR] %0t: write ack without a strobe", $time);
            error_count++;
        end
    assert property (@(posedge clk) disable iff (srst) i_rd |=> o_rd_ack)
        else begin
            $display("[ERROR] %0t: read ack missing one cycle after strobe", $time);
            error_count++;
        end
    assert property (@(posedge clk) disable iff (srst) o_rd_ack |-> $past(i_rd))
        else begin
            $display("[ERROR] %0t: read ack without a strobe", $time);
            error_count++;
        end

    task automatic check_equal(input string what, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
        assert (got === exp)
        else begin
            $display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < DEPTH; i++) begin
            model[i] = '0;
        end
    endtask

    task automatic mem_write(input int addr, input logic [DW-1:0] data);
        logic [DW-1:0] status;
        reg_write(proxy_pkg::REG_MEM_ADDR, addr);
        reg_write(proxy_pkg::REG_MEM_WDATA, data);
        reg_write(proxy_pkg::REG_MEM_CMD, proxy_pkg::CMD_WRITE);
        wait_status(DONE, status);
        check_equal("error flag after write", status[ERR], 1'b0);
        model[addr] = data;
    endtask

    task automatic mem_read_check(input int addr);
        logic [DW-1:0] status;
        logic [DW-1:0] rdata;
        reg_write(proxy_pkg::REG_MEM_ADDR, addr);
        reg_write(proxy_pkg::REG_MEM_CMD, proxy_pkg::CMD_READ);
        wait_status(DONE, status);
        check_equal("error flag after read", status[ERR], 1'b0);
        reg_read(proxy_pkg::REG_MEM_RDATA, rdata);
        check_equal($sformatf("memory word %0d", addr), rdata, model[addr]);
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            tests_passed++;
            $display("[%0t] test %s: ok", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] test %s: FAILED with %0d errors", $time, name,
                     error_count - errs_before);
        end
    endtask

    initial begin
        logic [DW-1:0] rd;
        logic [DW-1:0] st;
        logic [DW-1:0] st_before;
        int            errs;
        int            bad_addr;
        int            addr;

        void'($urandom(32'he4e7));
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        i_wr      = 1'b0;
        i_wr_addr = '0;
        i_wr_data = '0;
        i_rd      = 1'b0;
        i_rd_addr = '0;
        srst      = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        srst = 1'b0;

        // ------------------------------
        // Reset clear and identity
        errs = error_count;
        clear_model();
        wait_status(INIT, st);
        check_equal("busy after init", st[BUSY], 1'b0);
        reg_read(proxy_pkg::REG_ID, rd);
        check_equal("REG_ID", rd, proxy_pkg::PROXY_ID);
        reg_read(proxy_pkg::REG_MEM_CMD, rd);
        check_equal("REG_MEM_CMD", rd, 32'h0);
        reg_read(4'hF, rd);
        check_equal("unmapped word", rd, 32'h0);
        end_test("reset and identity", errs);

        // ------------------------------
        // Scratch and read-only words
        errs = error_count;
        for (int i = 0; i < 8; i++) begin
            st_before = $urandom;
            reg_write(proxy_pkg::REG_SCRATCH, st_before);
            reg_read(proxy_pkg::REG_SCRATCH, rd);
            check_equal("REG_SCRATCH", rd, st_before);
        end
        reg_write(proxy_pkg::REG_ID, $urandom);
        reg_read(proxy_pkg::REG_ID, rd);
        check_equal("REG_ID after write", rd, proxy_pkg::PROXY_ID);
        reg_write(proxy_pkg::REG_STATUS, $urandom);
        reg_read(proxy_pkg::REG_STATUS, rd);
        // Idle with no command yet, so only init_done is set
        check_equal("REG_STATUS after write", rd, DW'(1) << INIT);
        end_test("scratch register", errs);

        // ------------------------------
        // Random writes read back in reverse order
        errs = error_count;
        for (int i = 0; i < 40; i++) begin
            addr = $urandom_range(0, DEPTH - 1);
            written_addrs.push_back(addr);
            mem_write(addr, $urandom);
        end
        for (int i = written_addrs.size() - 1; i >= 0; i--) begin
            mem_read_check(written_addrs[i]);
        end
        end_test("memory write and read", errs);

        // ------------------------------
        // Out of range commands
        errs = error_count;
        bad_addr = DEPTH + $urandom_range(0, 1023);
        reg_write(proxy_pkg::REG_MEM_ADDR, bad_addr);
        reg_write(proxy_pkg::REG_MEM_WDATA, $urandom);
        reg_write(proxy_pkg::REG_MEM_CMD, proxy_pkg::CMD_WRITE);
        reg_read(proxy_pkg::REG_STATUS, st);
        check_equal("error after bad write", st[ERR], 1'b1);
        // The last valid read left done set
        check_equal("done after bad write", st[DONE], 1'b1);
        reg_write(proxy_pkg::REG_MEM_CMD, proxy_pkg::CMD_READ);
        reg_read(proxy_pkg::REG_STATUS, st);
        check_equal("error after bad read", st[ERR], 1'b1);
        check_equal("done after bad read", st[DONE], 1'b1);
        // Valid read clears error and shows the aliased word untouched
        mem_read_check(bad_addr % DEPTH);
        mem_read_check(written_addrs[0]);
        end_test("error handling", errs);

        // ------------------------------
        // Clear command
        errs = error_count;
        reg_write(proxy_pkg::REG_MEM_CMD, proxy_pkg::CMD_CLEAR);
        wait_status(DONE, st);
        check_equal("error after clear", st[ERR], 1'b0);
        clear_model();
        foreach (written_addrs[i]) begin
            mem_read_check(written_addrs[i]);
        end
        end_test("clear command", errs);

        // ------------------------------
        // Command while the clear is busy
        errs = error_count;
        for (int i = 0; i < 8; i++) begin
            mem_write($urandom_range(0, DEPTH - 1), $urandom | 32'h1);
        end
        reg_write(proxy_pkg::REG_MEM_CMD, proxy_pkg::CMD_CLEAR);
        reg_write(proxy_pkg::REG_MEM_CMD, proxy_pkg::CMD_READ);
        reg_read(proxy_pkg::REG_STATUS, st);
        check_equal("busy during clear", st[BUSY], 1'b1);
        check_equal("error on busy command", st[ERR], 1'b1);
        wait_status(DONE, st);
        check_equal("error kept through clear", st[ERR], 1'b1);
        clear_model();
        for (addr = 0; addr < DEPTH; addr++) begin
            mem_read_check(addr);
        end
        end_test("busy rejection", errs);

        $display("tests: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : tb_proxy_top

`default_nettype wire

// File: src/proxy_top.sv
`timescale 1ns/1ps
`default_nettype none

module proxy_top #(
    parameter int DEPTH = 256
) (
    input  logic                                clk,
    input  logic                                srst,
    input  logic                                i_wr,
    input  logic [proxy_pkg::REG_ADDR_WID-1:0]  i_wr_addr,
    input  logic [proxy_pkg::REG_DATA_WID-1:0]  i_wr_data,
    output logic                                o_wr_ack,
    input  logic                                i_rd,
    input  logic [proxy_pkg::REG_ADDR_WID-1:0]  i_rd_addr,
    output logic [proxy_pkg::REG_DATA_WID-1:0]  o_rd_data,
    output logic                                o_rd_ack
);

    localparam int ADDR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // ------------------------------
    // Internal wires
    // ------------------------------
    logic                               cmd_valid;
    proxy_pkg::mem_cmd_e                cmd_op;
    logic [proxy_pkg::REG_DATA_WID-1:0] mem_addr;
    logic [proxy_pkg::REG_DATA_WID-1:0] mem_wdata;
    logic                               busy;
    logic                               done;
    logic                               error;
    logic                               init_done;
    logic [proxy_pkg::REG_DATA_WID-1:0] ctrl_rdata;

    logic                               clr_load;
    logic                               clr_inc;
    logic [ADDR_WID-1:0]                clr_count;
    logic                               clr_last;

    logic                               ram_we;
    logic [ADDR_WID-1:0]                ram_addr;
    logic [proxy_pkg::REG_DATA_WID-1:0] ram_wdata;
    logic [proxy_pkg::REG_DATA_WID-1:0] ram_rdata;

    // ------------------------------
    // Instances
    // ------------------------------
    proxy_regs u_regs (
        .clk         ( clk ),
        .srst        ( srst ),
        .i_wr        ( i_wr ),
        .i_wr_addr   ( i_wr_addr ),
        .i_wr_data   ( i_wr_data ),
        .o_wr_ack    ( o_wr_ack ),
        .i_rd        ( i_rd ),
        .i_rd_addr   ( i_rd_addr ),
        .o_rd_data   ( o_rd_data ),
        .o_rd_ack    ( o_rd_ack ),
        .o_cmd_valid ( cmd_valid ),
        .o_cmd_op    ( cmd_op ),
        .o_mem_addr  ( mem_addr ),
        .o_mem_wdata ( mem_wdata ),
        .i_busy      ( busy ),
        .i_done      ( done ),
        .i_error     ( error ),
        .i_init_done ( init_done ),
        .i_mem_rdata ( ctrl_rdata )
    );

    mem_proxy_ctrl #(
        .DEPTH ( DEPTH )
    ) u_ctrl (
        .clk         ( clk ),
        .srst        ( srst ),
        .i_cmd_valid ( cmd_valid ),
        .i_cmd_op    ( cmd_op ),
        .i_mem_addr  ( mem_addr ),
        .i_mem_wdata ( mem_wdata ),
        .o_busy      ( busy ),
        .o_done      ( done ),
        .o_error     ( error ),
        .o_init_done ( init_done ),
        .o_rdata     ( ctrl_rdata ),
        .o_clr_load  ( clr_load ),
        .o_clr_inc   ( clr_inc ),
        .i_clr_count ( clr_count ),
        .i_clr_last  ( clr_last ),
        .o_ram_we    ( ram_we ),
        .o_ram_addr  ( ram_addr ),
        .o_ram_wdata ( ram_wdata ),
        .i_ram_rdata ( ram_rdata )
    );

    clear_addr_counter #(
        .DEPTH ( DEPTH )
    ) u_clear_cnt (
        .clk     ( clk ),
        .srst    ( srst ),
        .i_load  ( clr_load ),
        .i_inc   ( clr_inc ),
        .o_count ( clr_count ),
        .o_last  ( clr_last )
    );

    mem_ram_sp #(
        .DEPTH ( DEPTH )
    ) u_ram (
        .clk     ( clk ),
        .i_we    ( ram_we ),
        .i_addr  ( ram_addr ),
        .i_wdata ( ram_wdata ),
        .o_rdata ( ram_rdata )
    );

endmodule : proxy_top

`default_nettype wire

// File: src/proxy_regs.sv
`timescale 1ns/1ps
`default_nettype none

module proxy_regs (
    input  logic                                clk,
    input  logic                                srst,

    // Host register port
    input  logic                                i_wr,
    input  logic [proxy_pkg::REG_ADDR_WID-1:0]  i_wr_addr,
    input  logic [proxy_pkg::REG_DATA_WID-1:0]  i_wr_data,
    output logic                                o_wr_ack,
    input  logic                                i_rd,
    input  logic [proxy_pkg::REG_ADDR_WID-1:0]  i_rd_addr,
    output logic [proxy_pkg::REG_DATA_WID-1:0]  o_rd_data,
    output logic                                o_rd_ack,

    // Command and operands towards the controller
    output logic                                o_cmd_valid,
    output proxy_pkg::mem_cmd_e                 o_cmd_op,
    output logic [proxy_pkg::REG_DATA_WID-1:0]  o_mem_addr,
    output logic [proxy_pkg::REG_DATA_WID-1:0]  o_mem_wdata,

    // Controller status
    input  logic                                i_busy,
    input  logic                                i_done,
    input  logic                                i_error,
    input  logic                                i_init_done,
    input  logic [proxy_pkg::REG_DATA_WID-1:0]  i_mem_rdata
);

    proxy_pkg::reg_addr_e                wr_reg;
    proxy_pkg::reg_addr_e                rd_reg;
    logic [proxy_pkg::REG_DATA_WID-1:0]  scratch;
    logic [proxy_pkg::REG_DATA_WID-1:0]  status_word;
    logic [proxy_pkg::REG_DATA_WID-1:0]  rd_mux;

    assign wr_reg = proxy_pkg::reg_addr_e'(i_wr_addr);
    assign rd_reg = proxy_pkg::reg_addr_e'(i_rd_addr);

    // ------------------------------
    // Host writes
    // ------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            o_wr_ack    <= 1'b0;
            o_cmd_valid <= 1'b0;
            scratch     <= '0;
            o_mem_addr  <= '0;
            o_mem_wdata <= '0;
        end else begin
            o_wr_ack    <= i_wr;
            o_cmd_valid <= i_wr && (wr_reg == proxy_pkg::REG_MEM_CMD);
            if (i_wr) begin
                case (wr_reg)
                    proxy_pkg::REG_SCRATCH:   scratch     <= i_wr_data;
                    proxy_pkg::REG_MEM_ADDR:  o_mem_addr  <= i_wr_data;
                    proxy_pkg::REG_MEM_WDATA: o_mem_wdata <= i_wr_data;
                    // Read-only and unmapped words ignore writes
                    default: ;
                endcase
            end
        end
    end

    // Opcode is only looked at together with o_cmd_valid
    always_ff @(posedge clk) begin
        if (i_wr && (wr_reg == proxy_pkg::REG_MEM_CMD)) begin
            o_cmd_op <= proxy_pkg::mem_cmd_e'(i_wr_data[1:0]);
        end
    end

    // ------------------------------
    // Status word and read mux
    // ------------------------------
    always_comb begin
        status_word = '0;
        status_word[proxy_pkg::STATUS_BUSY_BIT]      = i_busy;
        status_word[proxy_pkg::STATUS_DONE_BIT]      = i_done;
        status_word[proxy_pkg::STATUS_ERROR_BIT]     = i_error;
        status_word[proxy_pkg::STATUS_INIT_DONE_BIT] = i_init_done;
    end

    always_comb begin
        case (rd_reg)
            proxy_pkg::REG_ID:        rd_mux = proxy_pkg::PROXY_ID;
            proxy_pkg::REG_SCRATCH:   rd_mux = scratch;
            proxy_pkg::REG_MEM_ADDR:  rd_mux = o_mem_addr;
            proxy_pkg::REG_MEM_WDATA: rd_mux = o_mem_wdata;
            proxy_pkg::REG_MEM_RDATA: rd_mux = i_mem_rdata;
            proxy_pkg::REG_STATUS:    rd_mux = status_word;
            // Command register and holes read as zero
            default:                  rd_mux = '0;
        endcase
    end

    // Ack and data both land one cycle after the strobe
    always_ff @(posedge clk) begin
        if (srst) begin
            o_rd_ack <= 1'b0;
        end else begin
            o_rd_ack <= i_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd) begin
            o_rd_data <= rd_mux;
        end
    end

endmodule : proxy_regs

`default_nettype wire

// File: src/mem_proxy_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_proxy_ctrl #(
    parameter int DEPTH = 256
) (
    input  logic                                       clk,
    input  logic                                       srst,

    // Command from the register block
    input  logic                                       i_cmd_valid,
    input  proxy_pkg::mem_cmd_e                        i_cmd_op,
    input  logic [proxy_pkg::REG_DATA_WID-1:0]         i_mem_addr,
    input  logic [proxy_pkg::REG_DATA_WID-1:0]         i_mem_wdata,

    // Status back to the register block
    output logic                                       o_busy,
    output logic                                       o_done,
    output logic                                       o_error,
    output logic                                       o_init_done,
    output logic [proxy_pkg::REG_DATA_WID-1:0]         o_rdata,

    // Clear address counter
    output logic                                       o_clr_load,
    output logic                                       o_clr_inc,
    input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] i_clr_count,
    input  logic                                       i_clr_last,

    // RAM port
    output logic                                       o_ram_we,
    output logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] o_ram_addr,
    output logic [proxy_pkg::REG_DATA_WID-1:0]         o_ram_wdata,
    input  logic [proxy_pkg::REG_DATA_WID-1:0]         i_ram_rdata
);

    localparam int ADDR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [proxy_pkg::REG_DATA_WID-1:0] MEM_WORDS = DEPTH;

    proxy_pkg::proxy_state_e state;
    logic                    clearing;
    logic                    addr_in_range;
    logic                    cmd_accept;

    // ------------------------------
    // Command checks
    // ------------------------------
    assign clearing      = (state == proxy_pkg::ST_INIT) || (state == proxy_pkg::ST_CLEAR);
    assign addr_in_range = (i_mem_addr < MEM_WORDS);

    // Only IDLE accepts, which also implies init_done
    assign cmd_accept = i_cmd_valid && (state == proxy_pkg::ST_IDLE) &&
                        ((i_cmd_op == proxy_pkg::CMD_NOP) ||
                         (i_cmd_op == proxy_pkg::CMD_CLEAR) || addr_in_range);

    // INIT is not reported as busy, so busy stays low through reset
    assign o_busy = !clearing ? (state != proxy_pkg::ST_IDLE) : (state == proxy_pkg::ST_CLEAR);

    // ------------------------------
    // Counter and RAM drive
    // ------------------------------
    assign o_clr_load  = cmd_accept && (i_cmd_op == proxy_pkg::CMD_CLEAR);
    assign o_clr_inc   = clearing;

    assign o_ram_we    = clearing || (state == proxy_pkg::ST_WRITE);
    assign o_ram_addr  = clearing ? i_clr_count : i_mem_addr[ADDR_WID-1:0];
    assign o_ram_wdata = clearing ? '0 : i_mem_wdata;

    // ------------------------------
    // FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state       <= proxy_pkg::ST_INIT;
            o_done      <= 1'b0;
            o_error     <= 1'b0;
            o_init_done <= 1'b0;
        end else begin
            case (state)
                proxy_pkg::ST_INIT: begin
                    if (i_clr_last) begin
                        state       <= proxy_pkg::ST_IDLE;
                        o_init_done <= 1'b1;
                    end
                end
                proxy_pkg::ST_IDLE: begin
                    if (cmd_accept) begin
                        // NOP completes right away
                        o_done  <= (i_cmd_op == proxy_pkg::CMD_NOP);
                        o_error <= 1'b0;
                        case (i_cmd_op)
                            proxy_pkg::CMD_READ:  state <= proxy_pkg::ST_READ;
                            proxy_pkg::CMD_WRITE: state <= proxy_pkg::ST_WRITE;
                            proxy_pkg::CMD_CLEAR: state <= proxy_pkg::ST_CLEAR;
                            default: ;
                        endcase
                    end
                end
                proxy_pkg::ST_WRITE: begin
                    state  <= proxy_pkg::ST_IDLE;
                    o_done <= 1'b1;
                end
                // Address goes to the RAM here, data comes back next cycle
                proxy_pkg::ST_READ: begin
                    state <= proxy_pkg::ST_READ_CAPTURE;
                end
                proxy_pkg::ST_READ_CAPTURE: begin
                    state  <= proxy_pkg::ST_IDLE;
                    o_done <= 1'b1;
                end
                proxy_pkg::ST_CLEAR: begin
                    if (i_clr_last) begin
                        state  <= proxy_pkg::ST_IDLE;
                        o_done <= 1'b1;
                    end
                end
                default: begin
                    state <= proxy_pkg::ST_INIT;
                end
            endcase

            // Busy, not yet initialized, or out of range
            if (i_cmd_valid && !cmd_accept) begin
                o_error <= 1'b1;
            end
        end
    end

    // Read word holds until the next read
    always_ff @(posedge clk) begin
        if (state == proxy_pkg::ST_READ_CAPTURE) begin
            o_rdata <= i_ram_rdata;
        end
    end

endmodule : mem_proxy_ctrl

`default_nettype wire

// File: src/mem_ram_sp.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ram_sp #(
    parameter int DEPTH = 256
) (
    input  logic                                       clk,
    input  logic                                       i_we,
    input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] i_addr,
    input  logic [proxy_pkg::REG_DATA_WID-1:0]         i_wdata,
    output logic [proxy_pkg::REG_DATA_WID-1:0]         o_rdata
);

    logic [proxy_pkg::REG_DATA_WID-1:0] mem [DEPTH];

    // Read-first single port, one cycle of read latency
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];
    end

endmodule : mem_ram_sp

`default_nettype wire

// File: src/clear_addr_counter.sv
`timescale 1ns/1ps
`default_nettype none

module clear_addr_counter #(
    parameter int DEPTH = 256
) (
    input  logic                                       clk,
    input  logic                                       srst,
    input  logic                                       i_load,
    input  logic                                       i_inc,
    output logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] o_count,
    output logic                                       o_last
);

    localparam int ADDR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [ADDR_WID-1:0] LAST_ADDR = ADDR_WID'(DEPTH - 1);

    assign o_last = (o_count == LAST_ADDR);

    // Load wins over increment; wrap after the last word
    always_ff @(posedge clk) begin
        if (srst) begin
            o_count <= '0;
        end else if (i_load) begin
            o_count <= '0;
        end else if (i_inc) begin
            if (o_last) begin
                o_count <= '0;
            end else begin
                o_count <= o_count + 1'b1;
            end
        end
    end

endmodule : clear_addr_counter

`default_nettype wire

// File: src/proxy_pkg.sv
`default_nettype none

package proxy_pkg;

    // ------------------------------
    // Widths and identity
    // ------------------------------
    localparam int REG_DATA_WID = 32;
    localparam int REG_ADDR_WID = 4;

    // "MPRX" in ASCII
    localparam logic [REG_DATA_WID-1:0] PROXY_ID = 32'h4D505258;

    // ------------------------------
    // Register map
    // ------------------------------
    typedef enum logic [REG_ADDR_WID-1:0] {
        REG_ID        = 4'd0,
        REG_SCRATCH   = 4'd1,
        REG_MEM_ADDR  = 4'd2,
        REG_MEM_WDATA = 4'd3,
        REG_MEM_CMD   = 4'd4,
        REG_MEM_RDATA = 4'd5,
        REG_STATUS    = 4'd6
    } reg_addr_e;

    // Bit positions in REG_STATUS
    localparam int STATUS_BUSY_BIT      = 0;
    localparam int STATUS_DONE_BIT      = 1;
    localparam int STATUS_ERROR_BIT     = 2;
    localparam int STATUS_INIT_DONE_BIT = 3;

    // ------------------------------
    // Memory commands and FSM states
    // ------------------------------
    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,
        CMD_READ  = 2'd1,
        CMD_WRITE = 2'd2,
        CMD_CLEAR = 2'd3
    } mem_cmd_e;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_READ_CAPTURE,
        ST_CLEAR
    } proxy_state_e;

endpackage : proxy_pkg

`default_nettype wire
